// ==== rtl/attn_cfg.svh ====
/* Width and count settings shared by the QKV projection engine
   Dimensions wider than 16 bits and SRAMs beyond 64K words are not supported */
`ifndef ATTN_CFG_SVH
`define ATTN_CFG_SVH

// SRAM word and arithmetic width, sums wrap here
`define ATTN_DATA_W 32

// SRAM address width for all three SRAMs
`define ATTN_ADDR_W 16

// One matrix dimension as packed in the header words
`define ATTN_DIM_W 16

// Weight matrices stored back to back (Q, K, V)
`define ATTN_NUM_W 3

`endif

// ==== rtl/attn_pkg.sv ====
/* Shared types for the QKV projection engine
   Widths come from attn_cfg.svh */
`default_nettype none

`include "attn_cfg.svh"

package attn_pkg;

  typedef logic [`ATTN_DATA_W-1:0] data_t;  // SRAM word or running sum
  typedef logic [`ATTN_ADDR_W-1:0] addr_t;
  typedef logic [`ATTN_DIM_W-1:0]  dim_t;   // Dimension or loop index

  // Weight matrix currently walked by the sequencer
  typedef enum logic [$clog2(`ATTN_NUM_W)-1:0] {
    MAT_Q = 2'd0,
    MAT_K = 2'd1,
    MAT_V = 2'd2
  } mat_sel_t;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_FETCH = 3'd1,  // Header words
    ST_ISSUE = 3'd2,  // One read pair per cycle
    ST_DRAIN = 3'd3   // Wait for final write
  } seq_state_t;

endpackage

`default_nettype wire

// ==== rtl/qkv_sequencer.sv ====
/* Job control and SRAM read addressing for Q, K and V
   Expects R, K and C of at least 1 and one-cycle SRAM reads */
`timescale 1ns/1ps
`default_nettype none

`include "attn_cfg.svh"

module qkv_sequencer (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   dut_valid,
  output logic                  dut_ready,
  input  wire  attn_pkg::data_t input_read_data,
  input  wire  attn_pkg::data_t weight_read_data,
  output attn_pkg::addr_t       input_read_address,
  output attn_pkg::addr_t       weight_read_address,
  output logic                  issue_valid,
  output logic                  first_term,
  output logic                  last_term,
  output logic                  last_job,
  input  wire                   job_done
);
  import attn_pkg::*;

  seq_state_t state;
  seq_state_t next_state;
  logic       fetch_phase;  // High while header words are on the read bus
  logic       accept;
  dim_t       r_dim;
  dim_t       k_dim;
  dim_t       c_dim;
  dim_t       row_cnt;
  dim_t       col_cnt;
  dim_t       term_cnt;
  mat_sel_t   mat_cnt;
  addr_t      in_row_base;   // 1 + i*K
  addr_t      wt_mat_base;   // 1 + m*K*C
  logic       last_col;
  logic       last_row;
  logic       last_mat;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  assign accept = dut_valid && dut_ready;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE:  if (accept) next_state = ST_FETCH;
      ST_FETCH: if (fetch_phase) next_state = ST_ISSUE;
      ST_ISSUE: if (last_job) next_state = ST_DRAIN;
      ST_DRAIN: if (job_done) next_state = ST_IDLE;
      default:  next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state       <= ST_IDLE;
      dut_ready   <= 1'b0;
      fetch_phase <= 1'b0;
    end else begin
      state       <= next_state;
      dut_ready   <= (next_state == ST_IDLE);  // Matches state == ST_IDLE outside reset
      fetch_phase <= (state == ST_FETCH) && !fetch_phase;
    end
  end

  // Header words arrive one cycle after address 0
  always_ff @(posedge clk) begin
    if (state == ST_FETCH && fetch_phase) begin
      r_dim <= input_read_data[`ATTN_DATA_W-1 -: `ATTN_DIM_W];
      k_dim <= input_read_data[`ATTN_DIM_W-1:0];
      c_dim <= weight_read_data[`ATTN_DIM_W-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // Issue flags
  // ----------------------------------------------------------------------
  assign last_col    = (col_cnt == c_dim - 1'b1);
  assign last_row    = (row_cnt == r_dim - 1'b1);
  assign last_mat    = (mat_cnt == mat_sel_t'(`ATTN_NUM_W - 1));
  assign issue_valid = (state == ST_ISSUE);
  assign first_term  = issue_valid && (term_cnt == '0);
  assign last_term   = issue_valid && (term_cnt == k_dim - 1'b1);
  assign last_job    = last_term && last_col && last_row && last_mat;

  // ----------------------------------------------------------------------
  // Loop counters and read addresses
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      term_cnt            <= '0;
      col_cnt             <= '0;
      row_cnt             <= '0;
      mat_cnt             <= MAT_Q;
      in_row_base         <= '0;
      wt_mat_base         <= '0;
      input_read_address  <= '0;
      weight_read_address <= '0;
    end else if (state == ST_FETCH) begin
      term_cnt            <= '0;
      col_cnt             <= '0;
      row_cnt             <= '0;
      mat_cnt             <= MAT_Q;
      in_row_base         <= addr_t'(1);
      wt_mat_base         <= addr_t'(1);
      // Address 0 goes out first and data starts at word 1
      input_read_address  <= fetch_phase ? addr_t'(1) : '0;
      weight_read_address <= fetch_phase ? addr_t'(1) : '0;
    end else if (state == ST_ISSUE) begin
      if (!last_term) begin
        term_cnt            <= term_cnt + 1'b1;
        input_read_address  <= input_read_address + 1'b1;
        weight_read_address <= weight_read_address + 1'b1;
      end else begin
        term_cnt <= '0;
        if (!last_col) begin
          col_cnt             <= col_cnt + 1'b1;
          input_read_address  <= in_row_base;                  // Same row again
          weight_read_address <= weight_read_address + 1'b1;   // Next column follows
        end else begin
          col_cnt <= '0;
          if (!last_row) begin
            row_cnt             <= row_cnt + 1'b1;
            in_row_base         <= input_read_address + 1'b1;
            input_read_address  <= input_read_address + 1'b1;
            weight_read_address <= wt_mat_base;
          end else begin
            row_cnt     <= '0;
            in_row_base <= addr_t'(1);
            if (!last_mat) begin
              mat_cnt             <= mat_sel_t'(mat_cnt + 1'b1);
              input_read_address  <= addr_t'(1);
              // Next weight matrix sits right after this one
              wt_mat_base         <= weight_read_address + 1'b1;
              weight_read_address <= weight_read_address + 1'b1;
            end else begin
              input_read_address  <= '0;
              weight_read_address <= '0;
            end
          end
        end
      end
    end else begin
      input_read_address  <= '0;
      weight_read_address <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mac_pipeline.sv ====
/* Three-stage multiply-accumulate, issue to sum_valid is 3 cycles
   Unsigned arithmetic, products and sums wrap at the data width */
`timescale 1ns/1ps
`default_nettype none

module mac_pipeline (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   issue_valid,
  input  wire                   first_term,
  input  wire                   last_term,
  input  wire                   last_job,
  input  wire  attn_pkg::data_t input_read_data,
  input  wire  attn_pkg::data_t weight_read_data,
  output logic                  sum_valid,
  output logic                  sum_last,
  output attn_pkg::data_t       sum_data
);
  import attn_pkg::*;

  logic  valid_d1;
  logic  first_d1;
  logic  last_d1;
  logic  job_d1;
  logic  valid_d2;
  logic  first_d2;
  logic  last_d2;
  logic  job_d2;
  data_t in_op;
  data_t wt_op;
  data_t product;

  // ----------------------------------------------------------------------
  // Flag delay line, aligned with SRAM data then with the operands
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_d1 <= 1'b0;
      first_d1 <= 1'b0;
      last_d1  <= 1'b0;
      job_d1   <= 1'b0;
      valid_d2 <= 1'b0;
      first_d2 <= 1'b0;
      last_d2  <= 1'b0;
      job_d2   <= 1'b0;
      sum_valid <= 1'b0;
      sum_last  <= 1'b0;
    end else begin
      valid_d1 <= issue_valid;
      first_d1 <= first_term;
      last_d1  <= last_term;
      job_d1   <= last_job;
      valid_d2 <= valid_d1;
      first_d2 <= first_d1;
      last_d2  <= last_d1;
      job_d2   <= job_d1;
      sum_valid <= valid_d2 && last_d2;  // One cycle per finished dot product
      sum_last  <= valid_d2 && job_d2;
    end
  end

  // Operand registers take the returning read data
  always_ff @(posedge clk) begin
    if (valid_d1) begin
      in_op <= input_read_data;
      wt_op <= weight_read_data;
    end
  end

  assign product = in_op * wt_op;  // Upper half dropped

  // Accumulator restarts on the first term of each run
  always_ff @(posedge clk) begin
    if (valid_d2)
      sum_data <= first_d2 ? product : sum_data + product;
  end

endmodule

`default_nettype wire

// ==== rtl/result_writer.sv ====
/* Result SRAM write port, one cycle after each sum
   Addresses run from 0 and wrap back to 0 after the final write */
`timescale 1ns/1ps
`default_nettype none

module result_writer (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   sum_valid,
  input  wire                   sum_last,
  input  wire  attn_pkg::data_t sum_data,
  output logic                  result_write_enable,
  output attn_pkg::addr_t       result_write_address,
  output attn_pkg::data_t       result_write_data,
  output logic                  job_done
);

  // ----------------------------------------------------------------------
  // Write strobe and done pulse
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result_write_enable <= 1'b0;
      job_done            <= 1'b0;
    end else begin
      result_write_enable <= sum_valid;
      job_done            <= sum_valid && sum_last;  // Same cycle as final write
    end
  end

  // Address of the write in progress, moves on once it is out
  always_ff @(posedge clk) begin
    if (!reset_n || job_done)
      result_write_address <= '0;
    else if (result_write_enable)
      result_write_address <= result_write_address + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (sum_valid)
      result_write_data <= sum_data;
  end

endmodule

`default_nettype wire

// ==== rtl/attn_qkv_top.sv ====
/* Q, K and V projection engine, start with a dut_valid pulse while dut_ready is high
   Input and weight SRAM write ports stay idle, SRAM reads take one cycle */
`timescale 1ns/1ps
`default_nettype none

module attn_qkv_top (
  input  wire                   clk,
  input  wire                   reset_n,
  input  wire                   dut_valid,
  output logic                  dut_ready,
  // Input SRAM
  output logic                  input_write_enable,
  output attn_pkg::addr_t       input_write_address,
  output attn_pkg::data_t       input_write_data,
  output attn_pkg::addr_t       input_read_address,
  input  wire  attn_pkg::data_t input_read_data,
  // Weight SRAM
  output logic                  weight_write_enable,
  output attn_pkg::addr_t       weight_write_address,
  output attn_pkg::data_t       weight_write_data,
  output attn_pkg::addr_t       weight_read_address,
  input  wire  attn_pkg::data_t weight_read_data,
  // Result SRAM, write only
  output logic                  result_write_enable,
  output attn_pkg::addr_t       result_write_address,
  output attn_pkg::data_t       result_write_data
);
  import attn_pkg::*;

  logic  issue_valid;
  logic  first_term;
  logic  last_term;
  logic  last_job;
  logic  sum_valid;
  logic  sum_last;
  data_t sum_data;
  logic  job_done;

  // Operand SRAMs are never written
  assign input_write_enable   = 1'b0;
  assign input_write_address  = '0;
  assign input_write_data     = '0;
  assign weight_write_enable  = 1'b0;
  assign weight_write_address = '0;
  assign weight_write_data    = '0;

  // ----------------------------------------------------------------------
  // Sequencer, MAC and writer
  // ----------------------------------------------------------------------
  qkv_sequencer u_seq (
    .clk                 (clk),
    .reset_n             (reset_n),
    .dut_valid           (dut_valid),
    .dut_ready           (dut_ready),
    .input_read_data     (input_read_data),
    .weight_read_data    (weight_read_data),
    .input_read_address  (input_read_address),
    .weight_read_address (weight_read_address),
    .issue_valid         (issue_valid),
    .first_term          (first_term),
    .last_term           (last_term),
    .last_job            (last_job),
    .job_done            (job_done)
  );

  mac_pipeline u_mac (
    .clk              (clk),
    .reset_n          (reset_n),
    .issue_valid      (issue_valid),
    .first_term       (first_term),
    .last_term        (last_term),
    .last_job         (last_job),
    .input_read_data  (input_read_data),
    .weight_read_data (weight_read_data),
    .sum_valid        (sum_valid),
    .sum_last         (sum_last),
    .sum_data         (sum_data)
  );

  result_writer u_wr (
    .clk                  (clk),
    .reset_n              (reset_n),
    .sum_valid            (sum_valid),
    .sum_last             (sum_last),
    .sum_data             (sum_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data),
    .job_done             (job_done)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
/* Clock and reset for the QKV testbench, 8 ns period
   reset_n is low for the first 2 rising edges and rises 1 ns after the second */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic reset_n
);
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_n = 1'b1;  // Same drive delay as the stimulus
  end

endmodule

`default_nettype wire

// ==== testbench/tb_qkv.sv ====
/* Testbench for the QKV projection engine with SRAMs modelled as one-cycle reads
   Data comes from a fixed-seed LFSR and each result is compared with a reference dot product */
`timescale 1ns/1ps
`default_nettype none

module tb_qkv;
  import attn_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'he448bbde;
  localparam int MEM_WORDS = 256;
  localparam int JOB_SLACK = 40;  // Cycles per test on top of 3*R*C*K
  // Five tests with two jobs in the last one
  localparam int CYCLE_LIMIT = 5 * JOB_SLACK
                             + 3 * (2*2*2 + 3*2*4 + 1*1*1 + 2*2*3 + 1*3*2);

  logic  clk;
  logic  reset_n;
  logic  dut_valid;
  logic  dut_ready;
  logic  input_write_enable;
  addr_t input_write_address;
  data_t input_write_data;
  addr_t input_read_address;
  data_t input_read_data = '0;
  logic  weight_write_enable;
  addr_t weight_write_address;
  data_t weight_write_data;
  addr_t weight_read_address;
  data_t weight_read_data = '0;
  logic  result_write_enable;
  addr_t result_write_address;
  data_t result_write_data;

  data_t input_mem  [MEM_WORDS];
  data_t weight_mem [MEM_WORDS];
  data_t result_mem [MEM_WORDS];

  logic [31:0] lfsr_state = LFSR_SEED;
  int job_r;
  int job_k;
  int job_c;
  int result_limit = 0;       // 3*R*C of the running job
  int write_count = 0;
  int first_write_addr = -1;
  int error_count = 0;
  int test_count = 0;
  int test_fail_count = 0;
  int cycle_count = 0;
  logic compare_busy = 1'b0;
  event compare_start;

  tb_clk_gen u_clk_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  attn_qkv_top u_attn_qkv_top (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .input_write_enable   (input_write_enable),
    .input_write_address  (input_write_address),
    .input_write_data     (input_write_data),
    .input_read_address   (input_read_address),
    .input_read_data      (input_read_data),
    .weight_write_enable  (weight_write_enable),
    .weight_write_address (weight_write_address),
    .weight_write_data    (weight_write_data),
    .weight_read_address  (weight_read_address),
    .weight_read_data     (weight_read_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  // ----------------------------------------------------------------------
  // SRAM models
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    input_read_data  <= input_mem[input_read_address];   // One-cycle read
    weight_read_data <= weight_mem[weight_read_address];
  end

  always @(posedge clk) begin
    if (result_write_enable === 1'b1) begin
      if (write_count == 0)
        first_write_addr = int'(result_write_address);
      write_count++;
      if (int'(result_write_address) >= result_limit) begin
        $display("result write to address %0d, at or beyond %0d, at %0t",
                 result_write_address, result_limit, $time);
        error_count++;
      end else begin
        result_mem[result_write_address] = result_write_data;
      end
    end
  end

  // Operand SRAMs must never see a write
  always @(posedge clk) begin
    if (input_write_enable !== 1'b0 || weight_write_enable !== 1'b0) begin
      $display("operand SRAM write enable raised at %0t", $time);
      error_count++;
    end
    if (input_write_address !== '0 || input_write_data !== '0 ||
        weight_write_address !== '0 || weight_write_data !== '0) begin
      $display("operand SRAM write address or data not held at zero at %0t", $time);
      error_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_shift(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output data_t value);
    value = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_shift(lfsr_state);
      value = {value[30:0], lfsr_state[0]};  // One step per bit
    end
  endtask

  // Unused words hold an address pattern so stray reads show up
  task automatic fill_memories;
    for (int a = 0; a < MEM_WORDS; a++) begin
      input_mem[a]  = {16'hc0de ^ 16'(a), 16'(a)};
      weight_mem[a] = {16'h5eed ^ 16'(a), ~16'(a)};
      result_mem[a] = {~16'(a), 16'(a)};
    end
  endtask

  task automatic load_job(input int r, input int k, input int c, input int bits);
    data_t value;
    job_r = r;
    job_k = k;
    job_c = c;
    result_limit = 3 * r * c;
    fill_memories();
    input_mem[0]  = {16'(r), 16'(k)};   // R in the upper half
    weight_mem[0] = {16'(k), 16'(c)};   // K in the upper half
    for (int n = 0; n < r * k; n++) begin
      random_bits(bits, value);
      input_mem[1 + n] = value;
    end
    for (int n = 0; n < 3 * k * c; n++) begin
      random_bits(bits, value);
      weight_mem[1 + n] = value;
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model and compare
  // ----------------------------------------------------------------------
  // Row i of I against column j of weight matrix m with 32-bit wrap
  function automatic data_t expected_value(input int m, input int i, input int j);
    data_t acc;
    acc = '0;
    for (int k = 0; k < job_k; k++)
      acc = acc + input_mem[1 + i*job_k + k] * weight_mem[1 + m*job_k*job_c + j*job_k + k];
    return acc;
  endfunction

  function automatic string mat_name(input int m);
    case (m)
      0:       return "Q";
      1:       return "K";
      default: return "V";
    endcase
  endfunction

  always begin
    int    addr;
    data_t expected;
    @(compare_start);
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < job_r; i++) begin
        for (int j = 0; j < job_c; j++) begin
          addr     = m*job_r*job_c + i*job_c + j;
          expected = expected_value(m, i, j);
          if (result_mem[addr] !== expected) begin
            $display("mismatch at %0t: %s[%0d][%0d] at address %0d, expected %h, got %h",
                     $time, mat_name(m), i, j, addr, expected, result_mem[addr]);
            error_count++;
          end
        end
      end
    end
    if (write_count != result_limit) begin
      $display("job wrote %0d results instead of %0d", write_count, result_limit);
      error_count++;
    end
    if (first_write_addr != 0) begin
      $display("first result of the job went to address %0d instead of 0",
               first_write_addr);
      error_count++;
    end
    compare_busy = 1'b0;
  end

  // ----------------------------------------------------------------------
  // Job control
  // ----------------------------------------------------------------------
  // Called 1 ns after a rising edge
  task automatic start_job;
    if (dut_ready !== 1'b1) begin
      $display("dut_ready low when a job was due to start at %0t", $time);
      error_count++;
    end
    dut_valid = 1'b1;
    @(posedge clk);
    #1;
    dut_valid = 1'b0;
    if (dut_ready !== 1'b0) begin
      $display("dut_ready did not fall after the start at %0t", $time);
      error_count++;
    end
  endtask

  task automatic run_job(input int r, input int k, input int c, input int bits);
    load_job(r, k, c, bits);
    write_count      = 0;
    first_write_addr = -1;
    start_job();
    while (dut_ready !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    compare_busy = 1'b1;
    -> compare_start;
    wait (!compare_busy);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      test_fail_count++;
      $display("test %s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int errors_before;
    dut_valid = 1'b0;
    fill_memories();

    // Test 1 checks reset and ready
    errors_before = error_count;
    @(posedge clk);
    #1;
    if (dut_ready !== 1'b0) begin
      $display("dut_ready not low during reset at %0t", $time);
      error_count++;
    end
    wait (reset_n === 1'b1);
    for (int n = 0; n < 4 && dut_ready !== 1'b1; n++) begin
      @(posedge clk);
      #1;
    end
    if (dut_ready !== 1'b1) begin
      $display("dut_ready did not rise after reset");
      error_count++;
    end
    if (result_write_enable !== 1'b0) begin
      $display("result write enable not low after reset at %0t", $time);
      error_count++;
    end
    finish_test("1 reset and idle write ports", errors_before);

    errors_before = error_count;
    run_job(2, 2, 2, 4);
    finish_test("2 small 2x2x2", errors_before);

    errors_before = error_count;
    run_job(3, 4, 2, 32);
    finish_test("3 random 3x4x2 with wrap", errors_before);

    errors_before = error_count;
    run_job(1, 1, 1, 8);
    finish_test("4 single products", errors_before);

    errors_before = error_count;
    run_job(2, 3, 2, 16);
    run_job(1, 2, 3, 16);  // Starts as soon as ready is back
    finish_test("5 back to back jobs", errors_before);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             test_count, test_count - test_fail_count, test_fail_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/attn_pkg.sv
rtl/qkv_sequencer.sv
rtl/mac_pipeline.sv
rtl/result_writer.sv
rtl/attn_qkv_top.sv
testbench/tb_clk_gen.sv
testbench/tb_qkv.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the QKV testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -Wno-fatal -f files.f --top-module tb_qkv \
  -Mdir "$BUILD_DIR" -o tb_qkv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_qkv_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
